// File: build.f
hdl/trg_pkg.sv
hdl/trg_apb_regs.sv
hdl/baseline_calib.sv
hdl/threshold_trigger.sv
hdl/trg_subsystem_top.sv
verif/tb_trg_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the trigger front end testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_trg_top -f build.f -o Vtb_trg_top
./obj_dir/Vtb_trg_top | tee sim.log
if grep -q "^TESTBENCH PASSED$" sim.log
then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: verif/tb_trg_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_trg_top;
    import trg_pkg::*;

    localparam int TDATA_WIDTH = 128;
    localparam int LANES       = TDATA_WIDTH / 16;
    localparam int POST_LEN    = 4;
    localparam int THRESHOLD   = 100;

    logic                   AXIS_ACLK;
    logic                   AXIS_ARESETN;
    logic [TDATA_WIDTH-1:0] s_axis_tdata;
    logic                   s_axis_tvalid;
    apb_req_t               apb_req;
    apb_rsp_t               apb_rsp;
    logic                   trig_flag;

    int seed;
    int errors;
    int pass_cnt;
    int fail_cnt;
    int base_exp;
    int evt_exp;

    trg_subsystem_top #(
        .TDATA_WIDTH      (TDATA_WIDTH),
        .CALIB_BEATS_LOG2 (4)
    ) dut (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .apb_req       (apb_req),
        .apb_rsp       (apb_rsp),
        .trig_flag     (trig_flag)
    );

    initial
    begin
        AXIS_ACLK = 1'b0;
        forever #4 AXIS_ACLK = ~AXIS_ACLK;
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] got);
        $display("Mismatch %s: expected 0x%08h, got 0x%08h", name, expected, got);
        errors++;
    endtask

    // one APB transfer, stream held idle while the bus is busy
    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        @(negedge AXIS_ACLK);
        s_axis_tvalid  = 1'b0;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge AXIS_ACLK);
        apb_req.penable = 1'b1;
        #2;
        if (apb_rsp.pready !== 1'b1)
        begin
            $display("no pready in the access phase at address 0x%02h", addr);
            errors++;
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge AXIS_ACLK);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused_rd;
        apb_access(1'b1, addr, data, unused_rd, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        apb_access(1'b0, addr, 32'h0, data, err);
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        if (err !== 1'b0)
            report_mismatch("pslverr", 32'h0, {31'h0, err});
    endtask

    task automatic read_check(input string name, input logic [7:0] addr,
                              input logic [31:0] expected);
        logic [31:0] rd;
        logic        err;
        apb_read(addr, rd, err);
        if (err !== 1'b0)
            report_mismatch("pslverr", 32'h0, {31'h0, err});
        if (rd !== expected)
            report_mismatch(name, expected, rd);
    endtask

    // poll until the masked field reads back as expected
    task automatic wait_reg(input logic [7:0] addr, input logic [31:0] mask,
                            input logic [31:0] expected, input int limit);
        logic [31:0] rd;
        logic        err;
        int          polls;
        polls = 0;
        apb_read(addr, rd, err);
        while (((rd & mask) !== expected) && polls < limit)
        begin
            polls++;
            apb_read(addr, rd, err);
        end
        if ((rd & mask) !== expected)
        begin
            $display("timed out waiting for register 0x%02h to reach 0x%08h", addr, expected);
            errors++;
        end
    endtask

    function automatic logic [TDATA_WIDTH-1:0] make_beat(input int quiet_val, input int hot_val,
                                                         input int hot_idx);
        logic [TDATA_WIDTH-1:0] beat;
        logic [11:0]            v;
        beat = '0;
        for (int i = 0; i < LANES; i++)
        begin
            v = (i == hot_idx) ? hot_val[11:0] : quiet_val[11:0];
            beat[16*i +: 16] = {v, 4'h0};
        end
        return beat;
    endfunction

    task automatic drive_beat(input logic [TDATA_WIDTH-1:0] data);
        @(negedge AXIS_ACLK);
        s_axis_tdata  = data;
        s_axis_tvalid = 1'b1;
    endtask

    // hot_idx below zero puts quiet_val on every lane
    task automatic send_beat(input int quiet_val, input int hot_val, input int hot_idx);
        drive_beat(make_beat(quiet_val, hot_val, hot_idx));
    endtask

    task automatic send_quiet(input int n);
        repeat (n) send_beat(base_exp, 0, -1);
    endtask

    // large samples with tvalid low must be ignored
    task automatic stream_gap(input int n);
        repeat (n)
        begin
            @(negedge AXIS_ACLK);
            s_axis_tdata  = {LANES{16'h7ff0}};
            s_axis_tvalid = 1'b0;
        end
    endtask

    task automatic enter_run();
        write_reg(REG_CTRL, 32'h0);
        write_reg(REG_CTRL, 32'h3);
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before)
        begin
            $display("%s: ok", name);
            pass_cnt++;
        end
        else
        begin
            $display("%s: failed with %0d errors", name, errors - err_before);
            fail_cnt++;
        end
    endtask

    task automatic check_register_map();
        int          e0;
        logic [31:0] rd;
        logic        err;
        e0 = errors;
        read_check("ctrl", REG_CTRL, 32'h0);
        read_check("threshold", REG_THRESHOLD, 32'h0);
        read_check("post_len", REG_POST_LEN, 32'd4);
        read_check("acqui_len", REG_ACQUI_LEN, 32'd64);
        read_check("status", REG_STATUS, 32'h0);
        read_check("baseline", REG_BASELINE, 32'h0);
        read_check("last_stamp", REG_LAST_STAMP, 32'h0);
        read_check("last_len", REG_LAST_LEN, 32'h0);
        read_check("event_count", REG_EVENT_COUNT, 32'h0);
        write_reg(REG_THRESHOLD, 32'h123);
        read_check("threshold", REG_THRESHOLD, 32'h123);
        // negative thresholds read back sign extended
        write_reg(REG_THRESHOLD, 32'h800);
        read_check("threshold", REG_THRESHOLD, 32'hffff_f800);
        write_reg(REG_POST_LEN, 32'h2a5);
        read_check("post_len", REG_POST_LEN, 32'h2a5);
        write_reg(REG_ACQUI_LEN, 32'h155);
        read_check("acqui_len", REG_ACQUI_LEN, 32'h155);
        apb_read(8'h40, rd, err);
        if (err !== 1'b1)
            report_mismatch("pslverr", 32'h1, {31'h0, err});
        apb_write(8'h40, 32'h1, err);
        if (err !== 1'b1)
            report_mismatch("pslverr", 32'h1, {31'h0, err});
        apb_write(REG_EVENT_COUNT, 32'h5, err);
        if (err !== 1'b1)
            report_mismatch("pslverr", 32'h1, {31'h0, err});
        read_check("event_count", REG_EVENT_COUNT, 32'h0);
        write_reg(REG_POST_LEN, POST_LEN);
        write_reg(REG_ACQUI_LEN, 32'd64);
        report_test("register map", e0);
    endtask

    task automatic calibrate_baseline();
        int                     e0;
        int                     s;
        int                     sum;
        logic [TDATA_WIDTH-1:0] beat;
        e0  = errors;
        sum = 0;
        write_reg(REG_CTRL, 32'h1);
        for (int b = 0; b < 16; b++)
        begin
            for (int l = 0; l < LANES; l++)
            begin
                s   = 200 + ($random(seed) % 16);
                sum = sum + s;
                beat[16*l +: 16] = {s[11:0], 4'h0};
            end
            drive_beat(beat);
            if (b == 5 || b == 11)
                stream_gap(2);
        end
        wait_reg(REG_STATUS, 32'h1, 32'h1, 20);
        // 16 beats of 8 lanes
        base_exp = sum >>> 7;
        read_check("baseline", REG_BASELINE, base_exp);
        report_test("calibration", e0);
    endtask

    task automatic single_pulse_event();
        int e0;
        e0 = errors;
        write_reg(REG_THRESHOLD, THRESHOLD);
        enter_run();
        // one count below threshold stays quiet
        repeat (6) send_beat(base_exp, base_exp + THRESHOLD - 1, 5);
        send_beat(base_exp, base_exp + THRESHOLD, 5);
        send_quiet(POST_LEN);
        evt_exp++;
        wait_reg(REG_EVENT_COUNT, 32'hffff_ffff, evt_exp, 20);
        read_check("last_stamp", REG_LAST_STAMP, 32'd6);
        read_check("last_len", REG_LAST_LEN, 1 + POST_LEN);
        read_check("status", REG_STATUS, 32'h1);
        report_test("single pulse", e0);
    endtask

    task automatic truncated_window();
        int e0;
        e0 = errors;
        write_reg(REG_ACQUI_LEN, 32'd12);
        enter_run();
        send_quiet(2);
        repeat (12) send_beat(base_exp + THRESHOLD + 50, 0, -1);
        send_quiet(2);
        evt_exp++;
        wait_reg(REG_EVENT_COUNT, 32'hffff_ffff, evt_exp, 20);
        read_check("last_stamp", REG_LAST_STAMP, 32'd2);
        read_check("last_len", REG_LAST_LEN, 32'd12);
        read_check("status", REG_STATUS, 32'h5);
        write_reg(REG_ACQUI_LEN, 32'd64);
        report_test("truncation", e0);
    endtask

    task automatic gapped_and_aborted_windows();
        int e0;
        e0 = errors;
        enter_run();
        send_quiet(3);
        stream_gap(2);
        send_beat(base_exp, base_exp + THRESHOLD, 7);
        send_quiet(2);
        stream_gap(3);
        // second hot beat restarts the quiet count
        send_beat(base_exp, base_exp + THRESHOLD + 20, 0);
        stream_gap(1);
        send_quiet(POST_LEN);
        evt_exp++;
        wait_reg(REG_EVENT_COUNT, 32'hffff_ffff, evt_exp, 20);
        read_check("last_stamp", REG_LAST_STAMP, 32'd3);
        read_check("last_len", REG_LAST_LEN, 32'd8);
        read_check("status", REG_STATUS, 32'h1);
        // open a window, then leave run before it closes
        send_beat(base_exp, base_exp + THRESHOLD, 2);
        send_quiet(1);
        read_check("status", REG_STATUS, 32'h3);
        if (trig_flag !== 1'b1)
            report_mismatch("trig_flag", 32'h1, {31'h0, trig_flag});
        write_reg(REG_CTRL, 32'h0);
        send_quiet(6);
        read_check("event_count", REG_EVENT_COUNT, evt_exp);
        read_check("status", REG_STATUS, 32'h1);
        if (trig_flag !== 1'b0)
            report_mismatch("trig_flag", 32'h0, {31'h0, trig_flag});
        report_test("stream gaps and abort", e0);
    endtask

    initial
    begin
        seed          = 32'h8591;
        errors        = 0;
        pass_cnt      = 0;
        fail_cnt      = 0;
        base_exp      = 0;
        evt_exp       = 0;
        AXIS_ARESETN  = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tvalid = 1'b0;
        apb_req       = '0;
        repeat (3) @(negedge AXIS_ACLK);
        AXIS_ARESETN = 1'b1;

        check_register_map();
        calibrate_baseline();
        single_pulse_event();
        truncated_window();
        gapped_and_aborted_windows();

        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/trg_subsystem_top.sv
`timescale 1ns/1ns
`default_nettype none

module trg_subsystem_top #(
    parameter int TDATA_WIDTH      = 128,
    parameter int CALIB_BEATS_LOG2 = 4
) (
    input  logic                   AXIS_ACLK,
    input  logic                   AXIS_ARESETN,
    input  logic [TDATA_WIDTH-1:0] s_axis_tdata,
    input  logic                   s_axis_tvalid,
    input  trg_pkg::apb_req_t      apb_req,
    output trg_pkg::apb_rsp_t      apb_rsp,
    output logic                   trig_flag
);
    import trg_pkg::*;

    trg_cfg_t    cfg;
    trg_event_t  evt;
    adc_sample_t baseline;
    logic        calib_done;

    trg_apb_regs u_regs (
        .AXIS_ACLK    (AXIS_ACLK),
        .AXIS_ARESETN (AXIS_ARESETN),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .cfg          (cfg),
        .baseline     (baseline),
        .calib_done   (calib_done),
        .trig_flag    (trig_flag),
        .evt          (evt)
    );

    baseline_calib #(
        .TDATA_WIDTH      (TDATA_WIDTH),
        .CALIB_BEATS_LOG2 (CALIB_BEATS_LOG2)
    ) u_calib (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .exec_state    (cfg.exec_state),
        .baseline      (baseline),
        .calib_done    (calib_done)
    );

    threshold_trigger #(
        .TDATA_WIDTH (TDATA_WIDTH)
    ) u_trigger (
        .AXIS_ACLK     (AXIS_ACLK),
        .AXIS_ARESETN  (AXIS_ARESETN),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tvalid (s_axis_tvalid),
        .cfg           (cfg),
        .baseline      (baseline),
        .trig_flag     (trig_flag),
        .evt           (evt)
    );

endmodule

`default_nettype wire

// File: hdl/threshold_trigger.sv
`timescale 1ns/1ns
`default_nettype none

module threshold_trigger #(
    parameter int TDATA_WIDTH = 128
) (
    input  logic                  AXIS_ACLK,
    input  logic                  AXIS_ARESETN,
    input  logic [TDATA_WIDTH-1:0] s_axis_tdata,
    input  logic                  s_axis_tvalid,
    input  trg_pkg::trg_cfg_t     cfg,
    input  trg_pkg::adc_sample_t  baseline,
    output logic                  trig_flag,
    output trg_pkg::trg_event_t   evt
);
    import trg_pkg::*;

    localparam int LANES  = TDATA_WIDTH / LANE_WIDTH;
    localparam int DIFF_W = ADC_WIDTH + 1;

    typedef enum logic {
        WIN_IDLE,
        WIN_OPEN
    } win_state_t;

    win_state_t       win_state;
    logic             run_prev;
    logic             running;
    logic             entering_run;
    logic             hot;
    logic             win_beat;
    logic             close_len;
    logic             close_quiet;
    logic [LANES-1:0] lane_hot;
    time_stamp_t      time_cnt;
    time_stamp_t      time_cur;
    time_stamp_t      win_stamp;
    win_len_t         win_len;
    win_len_t         quiet_cnt;
    win_len_t         len_next;
    win_len_t         quiet_next;

    // one extra bit keeps sample minus baseline from wrapping
    always_comb
    begin
        adc_sample_t              lane;
        logic signed [DIFF_W-1:0] diff;
        for (int i = 0; i < LANES; i++)
        begin
            lane        = s_axis_tdata[LANE_WIDTH*i + LANE_WIDTH-1 -: ADC_WIDTH];
            diff        = DIFF_W'(lane) - DIFF_W'(baseline);
            lane_hot[i] = diff >= DIFF_W'(cfg.threshold);
        end
    end

    assign running      = cfg.exec_state == EXEC_RUN;
    assign entering_run = running && !run_prev;
    assign time_cur     = entering_run ? '0 : time_cnt;
    assign hot          = s_axis_tvalid && running && (|lane_hot);

    // beat that belongs to a window, opening beat included
    assign win_beat    = s_axis_tvalid && running && (win_state == WIN_OPEN || hot);
    assign len_next    = (win_state == WIN_OPEN) ? win_len + 1'b1 : win_len_t'(1);
    assign quiet_next  = hot ? '0 : quiet_cnt + 1'b1;
    assign close_len   = win_beat && (len_next >= cfg.acqui_len);
    assign close_quiet = win_beat && (quiet_next >= cfg.post_len);

    assign trig_flag = win_state == WIN_OPEN;

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            win_state <= WIN_IDLE;
            run_prev  <= 1'b0;
            time_cnt  <= '0;
            win_stamp <= '0;
            win_len   <= '0;
            quiet_cnt <= '0;
            evt       <= '0;
        end
        else
        begin
            run_prev <= running;
            evt.done <= 1'b0;

            // sample time counts valid beats only
            if (running && s_axis_tvalid)
                time_cnt <= time_cur + 1'b1;
            else if (entering_run)
                time_cnt <= '0;

            if (!running)
            begin
                // abort, no event
                win_state <= WIN_IDLE;
            end
            else if (win_beat)
            begin
                win_len   <= len_next;
                quiet_cnt <= quiet_next;
                if (win_state == WIN_IDLE)
                    win_stamp <= time_cur;
                if (close_len || close_quiet)
                begin
                    win_state    <= WIN_IDLE;
                    evt.done     <= 1'b1;
                    evt.stamp    <= (win_state == WIN_IDLE) ? time_cur : win_stamp;
                    evt.length   <= len_next;
                    evt.over_len <= close_len;
                end
                else
                begin
                    win_state <= WIN_OPEN;
                end
            end
        end
    end

    a_flag_only_in_run: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        (cfg.exec_state != EXEC_RUN && $past(cfg.exec_state) != EXEC_RUN) |-> !trig_flag)
        else $error("trig_flag high outside run");

    a_len_bounded: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        (win_state == WIN_OPEN) |-> (win_len <= cfg.acqui_len))
        else $error("window longer than acqui_len");

endmodule

`default_nettype wire

// File: hdl/baseline_calib.sv
`timescale 1ns/1ns
`default_nettype none

module baseline_calib #(
    parameter int TDATA_WIDTH      = 128,
    parameter int CALIB_BEATS_LOG2 = 4
) (
    input  logic                 AXIS_ACLK,
    input  logic                 AXIS_ARESETN,
    input  logic [TDATA_WIDTH-1:0] s_axis_tdata,
    input  logic                 s_axis_tvalid,
    input  trg_pkg::exec_state_t exec_state,
    output trg_pkg::adc_sample_t baseline,
    output logic                 calib_done
);
    import trg_pkg::*;

    localparam int LANES     = TDATA_WIDTH / LANE_WIDTH;
    localparam int SHIFT     = CALIB_BEATS_LOG2 + $clog2(LANES);
    localparam int ACC_WIDTH = ADC_WIDTH + SHIFT;
    localparam int CNT_WIDTH = CALIB_BEATS_LOG2 + 1;
    localparam logic [CNT_WIDTH-1:0] LAST_BEAT = CNT_WIDTH'((1 << CALIB_BEATS_LOG2) - 1);

    exec_state_t                 exec_prev;
    logic                        busy;
    logic                        entering;
    logic                        active;
    logic signed [ACC_WIDTH-1:0] acc;
    logic signed [ACC_WIDTH-1:0] beat_sum;
    logic signed [ACC_WIDTH-1:0] acc_sum;
    logic [CNT_WIDTH-1:0]        beat_cnt;
    logic [CNT_WIDTH-1:0]        cnt_cur;

    // sum of all lanes in this beat, sign extended
    always_comb
    begin
        beat_sum = '0;
        for (int i = 0; i < LANES; i++)
        begin
            beat_sum = beat_sum + ACC_WIDTH'(adc_sample_t'(
                s_axis_tdata[LANE_WIDTH*i + LANE_WIDTH-1 -: ADC_WIDTH]));
        end
    end

    // the entry beat already counts, so start from zero combinationally
    assign entering = (exec_state == EXEC_CALIB) && (exec_prev != EXEC_CALIB);
    assign active   = (exec_state == EXEC_CALIB) && (entering || busy);
    assign acc_sum  = (entering ? '0 : acc) + beat_sum;
    assign cnt_cur  = entering ? '0 : beat_cnt;

    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            exec_prev  <= EXEC_IDLE;
            busy       <= 1'b0;
            acc        <= '0;
            beat_cnt   <= '0;
            baseline   <= '0;
            calib_done <= 1'b0;
        end
        else
        begin
            exec_prev <= exec_state;
            busy      <= active;
            if (entering)
                calib_done <= 1'b0;
            if (active && s_axis_tvalid)
            begin
                if (cnt_cur == LAST_BEAT)
                begin
                    // arithmetic shift, rounds toward minus infinity
                    baseline   <= adc_sample_t'(acc_sum >>> SHIFT);
                    calib_done <= 1'b1;
                    busy       <= 1'b0;
                end
                else
                begin
                    acc      <= acc_sum;
                    beat_cnt <= cnt_cur + 1'b1;
                end
            end
            else if (entering)
            begin
                acc      <= '0;
                beat_cnt <= '0;
            end
        end
    end

    a_done_in_calib: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        $rose(calib_done) |-> $past(exec_state) == EXEC_CALIB)
        else $error("calib_done rose outside calibrate");

endmodule

`default_nettype wire

// File: hdl/trg_apb_regs.sv
`timescale 1ns/1ns
`default_nettype none

module trg_apb_regs (
    input  logic                AXIS_ACLK,
    input  logic                AXIS_ARESETN,
    input  trg_pkg::apb_req_t   apb_req,
    output trg_pkg::apb_rsp_t   apb_rsp,
    output trg_pkg::trg_cfg_t   cfg,
    input  trg_pkg::adc_sample_t baseline,
    input  logic                calib_done,
    input  logic                trig_flag,
    input  trg_pkg::trg_event_t evt
);
    import trg_pkg::*;

    localparam int LEN_W = $bits(win_len_t);

    logic        access;
    logic        addr_hit;
    logic        addr_ro;
    logic        wr_en;
    logic [31:0] rd_data;

    time_stamp_t last_stamp;
    win_len_t    last_len;
    logic        last_over;
    logic [31:0] evt_count;

    // access phase, zero wait states
    assign access = apb_req.psel && apb_req.penable;

    always_comb
    begin
        rd_data  = '0;
        addr_hit = 1'b1;
        addr_ro  = 1'b0;
        case (apb_req.paddr)
            REG_CTRL:        rd_data = {30'b0, cfg.exec_state};
            REG_THRESHOLD:   rd_data = 32'(cfg.threshold);
            REG_POST_LEN:    rd_data = 32'(cfg.post_len);
            REG_ACQUI_LEN:   rd_data = 32'(cfg.acqui_len);
            REG_STATUS:
            begin
                rd_data = {29'b0, last_over, trig_flag, calib_done};
                addr_ro = 1'b1;
            end
            REG_BASELINE:
            begin
                // sign extended so software sees a plain int
                rd_data = 32'(baseline);
                addr_ro = 1'b1;
            end
            REG_LAST_STAMP:
            begin
                rd_data = 32'(last_stamp);
                addr_ro = 1'b1;
            end
            REG_LAST_LEN:
            begin
                rd_data = 32'(last_len);
                addr_ro = 1'b1;
            end
            REG_EVENT_COUNT:
            begin
                rd_data = evt_count;
                addr_ro = 1'b1;
            end
            default:         addr_hit = 1'b0;
        endcase
    end

    assign wr_en           = access && apb_req.pwrite && addr_hit && !addr_ro;
    assign apb_rsp.pready  = access;
    assign apb_rsp.pslverr = access && (!addr_hit || (apb_req.pwrite && addr_ro));
    assign apb_rsp.prdata  = (access && !apb_req.pwrite) ? rd_data : '0;

    // configuration registers
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            cfg.exec_state <= EXEC_IDLE;
            cfg.threshold  <= '0;
            cfg.post_len   <= win_len_t'(4);
            cfg.acqui_len  <= win_len_t'(64);
        end
        else if (wr_en)
        begin
            case (apb_req.paddr)
                REG_CTRL:      cfg.exec_state <= exec_state_t'(apb_req.pwdata[1:0]);
                REG_THRESHOLD: cfg.threshold  <= apb_req.pwdata[ADC_WIDTH-1:0];
                REG_POST_LEN:  cfg.post_len   <= apb_req.pwdata[LEN_W-1:0];
                REG_ACQUI_LEN: cfg.acqui_len  <= apb_req.pwdata[LEN_W-1:0];
                default:       cfg.exec_state <= cfg.exec_state;
            endcase
        end
    end

    // event record, loaded on every closed window
    always_ff @(posedge AXIS_ACLK)
    begin
        if (!AXIS_ARESETN)
        begin
            last_stamp <= '0;
            last_len   <= '0;
            last_over  <= 1'b0;
            evt_count  <= '0;
        end
        else if (evt.done)
        begin
            last_stamp <= evt.stamp;
            last_len   <= evt.length;
            last_over  <= evt.over_len;
            evt_count  <= evt_count + 1'b1;
        end
    end

    a_penable_needs_psel: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        apb_req.penable |-> apb_req.psel)
        else $error("penable high without psel");

    a_paddr_stable: assert property (@(posedge AXIS_ACLK) disable iff (!AXIS_ARESETN)
        (apb_req.psel && !apb_req.penable) |=> $stable(apb_req.paddr))
        else $error("paddr changed between setup and access");

endmodule

`default_nettype wire

// File: hdl/trg_pkg.sv
`default_nettype none

package trg_pkg;

    // lanes are 16 bits, sample sits in the top 12
    localparam int LANE_WIDTH = 16;
    localparam int ADC_WIDTH  = 12;

    typedef logic signed [ADC_WIDTH-1:0] adc_sample_t;
    typedef logic [15:0] time_stamp_t;
    typedef logic [9:0]  win_len_t;

    // code 2 is not used and behaves like idle
    typedef enum logic [1:0] {
        EXEC_IDLE  = 2'd0,
        EXEC_CALIB = 2'd1,
        EXEC_RUN   = 2'd3
    } exec_state_t;

    typedef struct packed {
        exec_state_t exec_state;
        adc_sample_t threshold;
        win_len_t    post_len;
        win_len_t    acqui_len;
    } trg_cfg_t;

    typedef struct packed {
        logic        done;
        time_stamp_t stamp;
        win_len_t    length;
        logic        over_len;
    } trg_event_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // byte offsets of the register map
    localparam logic [7:0] REG_CTRL        = 8'h00;
    localparam logic [7:0] REG_THRESHOLD   = 8'h04;
    localparam logic [7:0] REG_POST_LEN    = 8'h08;
    localparam logic [7:0] REG_ACQUI_LEN   = 8'h0C;
    localparam logic [7:0] REG_STATUS      = 8'h10;
    localparam logic [7:0] REG_BASELINE    = 8'h14;
    localparam logic [7:0] REG_LAST_STAMP  = 8'h18;
    localparam logic [7:0] REG_LAST_LEN    = 8'h1C;
    localparam logic [7:0] REG_EVENT_COUNT = 8'h20;

endpackage

`default_nettype wire
